//--- mips_isa_pkg.sv
package mips_isa_pkg;

    localparam int WORD_W  = 32;
    localparam int REG_AW  = 5;
    localparam int OP_W    = 6;
    localparam int FN_W    = 6;
    localparam int SHAMT_W = 5;
    localparam int IMM_W   = 16;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;
    typedef logic [OP_W-1:0]   opcode_t;
    typedef logic [FN_W-1:0]   funct_t;

    // major opcodes
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_J       = 6'h02;
    localparam opcode_t OP_JAL     = 6'h03;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_SLTI    = 6'h0a;
    localparam opcode_t OP_SLTIU   = 6'h0b;
    localparam opcode_t OP_ANDI    = 6'h0c;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_XORI    = 6'h0e;
    localparam opcode_t OP_LUI     = 6'h0f;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_SW      = 6'h2b;

    // function codes under OP_SPECIAL
    localparam funct_t FN_ADDU    = 6'h21;
    localparam funct_t FN_SUBU    = 6'h23;
    localparam funct_t FN_AND     = 6'h24;
    localparam funct_t FN_OR      = 6'h25;
    localparam funct_t FN_XOR     = 6'h26;
    localparam funct_t FN_NOR     = 6'h27;
    localparam funct_t FN_SLT     = 6'h2a;
    localparam funct_t FN_SLTU    = 6'h2b;
    localparam funct_t FN_SLL     = 6'h00;
    localparam funct_t FN_SRL     = 6'h02;
    localparam funct_t FN_SRA     = 6'h03;
    localparam funct_t FN_JR      = 6'h08;
    localparam funct_t FN_SYSCALL = 6'h0c;
    localparam funct_t FN_BREAK   = 6'h0d;

    // one instruction word, two field layouts
    typedef union packed {
        struct packed {
            opcode_t            opcode;
            reg_addr_t          rs;
            reg_addr_t          rt;
            reg_addr_t          rd;
            logic [SHAMT_W-1:0] shamt;
            funct_t             funct;
        } r;
        struct packed {
            opcode_t          opcode;
            reg_addr_t        rs;
            reg_addr_t        rt;
            logic [IMM_W-1:0] imm;  // also low half of the jump index
        } i;
    } inst_word_t;

endpackage

//--- id_ctrl_pkg.sv
package id_ctrl_pkg;

    import mips_isa_pkg::*;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_J,
        BR_JAL,
        BR_JR
    } br_kind_t;

    typedef enum logic [1:0] {
        IMM_NONE,
        IMM_ZERO,
        IMM_SIGN
    } imm_kind_t;

    typedef logic [4:0] exc_code_t;

    localparam exc_code_t EXC_SYS = 5'd8;
    localparam exc_code_t EXC_BP  = 5'd9;
    localparam exc_code_t EXC_RI  = 5'd10;

    localparam reg_addr_t REG_RA = 5'd31;  // link register for jal

endpackage

//--- id_decoder.sv
module id_decoder
    import mips_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  inst_word_t ds_inst,
    input  logic       ds_fs_ex,
    input  exc_code_t  ds_fs_exc_code,
    output logic       rs_read,
    output logic       rt_read,
    output alu_op_t    alu_op,
    output imm_kind_t  imm_kind,
    output logic       src1_is_sa,
    output logic       src1_is_pc,
    output logic       src2_is_8,
    output reg_addr_t  dest,
    output logic       gr_we,
    output logic       mem_we,
    output logic       load_op,
    output br_kind_t   br_kind,
    output logic       ds_ex,
    output exc_code_t  exc_code
);

    opcode_t op;
    funct_t  fn;
    logic    special;
    logic    r_alu;
    logic    r_shift;
    logic    i_zext;
    logic    i_alu;
    logic    inst_jr;
    logic    inst_sys;
    logic    inst_brk;
    logic    inst_lw;
    logic    inst_sw;
    logic    inst_beq;
    logic    inst_bne;
    logic    inst_j;
    logic    inst_jal;
    logic    inst_ok;

    assign op      = ds_inst.i.opcode;
    assign fn      = ds_inst.r.funct;
    assign special = (op == OP_SPECIAL);

    // unused fields must be zero, as in the ISA manual
    assign r_alu    = special && (ds_inst.r.shamt == '0) &&
                      (fn inside {FN_ADDU, FN_SUBU, FN_AND, FN_OR,
                                  FN_XOR, FN_NOR, FN_SLT, FN_SLTU});
    assign r_shift  = special && (ds_inst.r.rs == '0) && (fn inside {FN_SLL, FN_SRL, FN_SRA});
    assign inst_jr  = special && (fn == FN_JR) && (ds_inst.r.rt == '0) &&
                      (ds_inst.r.rd == '0) && (ds_inst.r.shamt == '0);
    assign inst_sys = special && (fn == FN_SYSCALL);  // code field ignored
    assign inst_brk = special && (fn == FN_BREAK);

    assign i_zext   = (op inside {OP_ANDI, OP_ORI, OP_XORI}) ||
                      ((op == OP_LUI) && (ds_inst.i.rs == '0));
    assign i_alu    = i_zext || (op inside {OP_ADDIU, OP_SLTI, OP_SLTIU});
    assign inst_lw  = (op == OP_LW);
    assign inst_sw  = (op == OP_SW);
    assign inst_beq = (op == OP_BEQ);
    assign inst_bne = (op == OP_BNE);
    assign inst_j   = (op == OP_J);
    assign inst_jal = (op == OP_JAL);

    assign inst_ok = r_alu || r_shift || inst_jr || inst_sys || inst_brk || i_alu ||
                     inst_lw || inst_sw || inst_beq || inst_bne || inst_j || inst_jal;

    assign rs_read = r_alu || inst_jr || (i_alu && (op != OP_LUI)) ||
                     inst_lw || inst_sw || inst_beq || inst_bne;
    assign rt_read = r_alu || r_shift || inst_sw || inst_beq || inst_bne;

    assign src1_is_sa = r_shift;
    assign src1_is_pc = inst_jal;   // link value is pc + 8 through the adder
    assign src2_is_8  = inst_jal;

    // illegal words fall through to zero
    assign dest    = inst_jal           ? REG_RA :
                     (i_alu || inst_lw) ? ds_inst.i.rt :
                     (r_alu || r_shift) ? ds_inst.r.rd : '0;
    assign gr_we   = (dest != '0);
    assign mem_we  = inst_sw;
    assign load_op = inst_lw;

    always_comb begin
        case (op)
            OP_SPECIAL: begin
                case (fn)
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    FN_SRA:  alu_op = ALU_SRA;
                    default: alu_op = ALU_ADD;
                endcase
            end
            OP_SLTI:  alu_op = ALU_SLT;
            OP_SLTIU: alu_op = ALU_SLTU;
            OP_ANDI:  alu_op = ALU_AND;
            OP_ORI:   alu_op = ALU_OR;
            OP_XORI:  alu_op = ALU_XOR;
            OP_LUI:   alu_op = ALU_LUI;
            default:  alu_op = ALU_ADD;  // addiu, lw, sw, jal
        endcase
    end

    always_comb begin
        case (1'b1)
            i_zext:                      imm_kind = IMM_ZERO;
            i_alu, inst_lw, inst_sw:     imm_kind = IMM_SIGN;
            default:                     imm_kind = IMM_NONE;
        endcase
    end

    always_comb begin
        case (1'b1)
            inst_beq: br_kind = BR_BEQ;
            inst_bne: br_kind = BR_BNE;
            inst_j:   br_kind = BR_J;
            inst_jal: br_kind = BR_JAL;
            inst_jr:  br_kind = BR_JR;
            default:  br_kind = BR_NONE;
        endcase
    end

    // fetch fault beats reserved, then syscall, then break
    assign ds_ex    = ds_fs_ex || !inst_ok || inst_sys || inst_brk;
    assign exc_code = ds_fs_ex ? ds_fs_exc_code :
                      !inst_ok ? EXC_RI :
                      inst_sys ? EXC_SYS :
                      inst_brk ? EXC_BP : '0;

    // at most one instruction class per word, so never a load and a store
    decode_onehot: assert final ($isunknown(ds_inst) ||
        $onehot0({r_alu, r_shift, inst_jr, inst_sys, inst_brk, i_alu,
                  inst_lw, inst_sw, inst_beq, inst_bne, inst_j, inst_jal}));

endmodule

//--- id_stage_reg.sv
module id_stage_reg
    import mips_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       flush,
    input  logic       fs_to_ds_valid,
    input  inst_word_t fs_inst,
    input  word_t      fs_pc,
    input  logic       fs_ex,
    input  exc_code_t  fs_exc_code,
    input  logic       es_allowin,
    input  logic       load_stall,
    output logic       ds_valid,
    output inst_word_t ds_inst,
    output word_t      ds_pc,
    output logic       ds_fs_ex,
    output exc_code_t  ds_fs_exc_code,
    output logic       ds_allowin,
    output logic       ds_to_es_valid
);

    logic ds_ready_go;

    assign ds_ready_go    = !load_stall;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (flush) begin
            ds_valid <= 1'b0;  // drop whatever is held or offered
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    // payload only moves on a real transfer
    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_inst        <= fs_inst;
            ds_pc          <= fs_pc;
            ds_fs_ex       <= fs_ex;
            ds_fs_exc_code <= fs_exc_code;
        end
    end

    hold_while_blocked: assert property (@(posedge clk) disable iff (reset)
        ds_valid && !ds_allowin && !flush |=>
            ds_valid && $stable(ds_inst) && $stable(ds_pc));

    flush_clears: assert property (@(posedge clk) disable iff (reset)
        flush |=> !ds_valid);

endmodule

//--- id_regfile.sv
module id_regfile
    import mips_isa_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata,
    output word_t     rdata1,
    output word_t     rdata2
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // $zero is hardwired
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    // a written register reads back its new value in the next cycle
    write_read_back: assert property (@(posedge clk) disable iff (reset)
        (we && (waddr != '0)) |=>
            ((raddr1 !== $past(waddr)) || (rdata1 === $past(wdata))) &&
            ((raddr2 !== $past(waddr)) || (rdata2 === $past(wdata))));

endmodule

//--- id_bypass.sv
module id_bypass
    import mips_isa_pkg::*;
(
    input  inst_word_t ds_inst,
    input  logic       rs_read,
    input  logic       rt_read,
    input  word_t      rdata1,
    input  word_t      rdata2,
    input  reg_addr_t  exe_dest,
    input  reg_addr_t  mem_dest,
    input  reg_addr_t  wb_dest,
    input  word_t      exe_result,
    input  word_t      mem_result,
    input  word_t      wb_result,
    input  logic       es_load_op,
    output word_t      rs_value,
    output word_t      rt_value,
    output logic       load_stall
);

    reg_addr_t rs;
    reg_addr_t rt;

    assign rs = ds_inst.i.rs;
    assign rt = ds_inst.i.rt;

    // a used, nonzero source matching a later stage's destination
    function automatic logic hit(reg_addr_t src, logic used, reg_addr_t dst);
        return used && (src != '0) && (src == dst);
    endfunction

    // youngest producer wins
    function automatic word_t pick(reg_addr_t src, logic used, word_t rf_val);
        if (hit(src, used, exe_dest)) begin
            return exe_result;
        end else if (hit(src, used, mem_dest)) begin
            return mem_result;
        end else if (hit(src, used, wb_dest)) begin
            return wb_result;
        end
        return rf_val;
    endfunction

    always_comb begin
        rs_value = pick(rs, rs_read, rdata1);
        rt_value = pick(rt, rt_read, rdata2);
    end

    // load data not ready until MEM
    assign load_stall = es_load_op &&
                        (hit(rs, rs_read, exe_dest) || hit(rt, rt_read, exe_dest));

    // $zero as a source never picks up a forwarded result
    zero_src_zero: assert final ($isunknown(ds_inst) ||
        (((rs != '0) || (rs_value == '0)) && ((rt != '0) || (rt_value == '0))));

endmodule

//--- id_operand_sel.sv
module id_operand_sel
    import mips_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  inst_word_t ds_inst,
    input  word_t      ds_pc,
    input  word_t      rs_value,
    input  word_t      rt_value,
    input  imm_kind_t  imm_kind,
    input  logic       src1_is_sa,
    input  logic       src1_is_pc,
    input  logic       src2_is_8,
    input  br_kind_t   br_kind,
    output word_t      src1,
    output word_t      src2,
    output word_t      store_data,
    output word_t      br_target
);

    word_t sign_imm;
    word_t imm_ext;
    word_t pc_plus4;

    assign sign_imm = {{16{ds_inst.i.imm[15]}}, ds_inst.i.imm};
    assign imm_ext  = (imm_kind == IMM_ZERO) ? {16'b0, ds_inst.i.imm} : sign_imm;
    assign pc_plus4 = ds_pc + 32'd4;

    assign src1 = src1_is_sa ? {27'b0, ds_inst.i.imm[10:6]} :  // shamt field
                  src1_is_pc ? ds_pc : rs_value;

    assign src2 = src2_is_8               ? 32'd8 :
                  (imm_kind != IMM_NONE)  ? imm_ext : rt_value;

    assign store_data = rt_value;

    always_comb begin
        case (br_kind)
            BR_BEQ, BR_BNE: br_target = pc_plus4 + {sign_imm[29:0], 2'b00};
            BR_J, BR_JAL:   br_target = {pc_plus4[31:28], ds_inst.i.rs, ds_inst.i.rt,
                                         ds_inst.i.imm, 2'b00};  // 26-bit index
            BR_JR:          br_target = rs_value;
            default:        br_target = pc_plus4;  // sequential
        endcase
    end

endmodule

//--- id_stage.sv
module id_stage
    import mips_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       flush,
    input  logic       fs_to_ds_valid,
    input  logic       fs_ex,
    input  inst_word_t fs_inst,
    input  word_t      fs_pc,
    input  exc_code_t  fs_exc_code,
    input  logic       es_allowin,
    input  logic       es_load_op,
    input  reg_addr_t  exe_dest,
    input  reg_addr_t  mem_dest,
    input  reg_addr_t  wb_dest,
    input  word_t      exe_result,
    input  word_t      mem_result,
    input  word_t      wb_result,
    input  logic       wb_we,
    input  reg_addr_t  wb_waddr,
    input  word_t      wb_wdata,
    output logic       ds_allowin,
    output logic       ds_to_es_valid,
    output word_t      es_pc,
    output alu_op_t    es_alu_op,
    output word_t      es_src1,
    output word_t      es_src2,
    output word_t      es_store_data,
    output reg_addr_t  es_dest,
    output logic       es_gr_we,
    output logic       es_mem_we,
    output logic       es_load_op_out,
    output br_kind_t   es_br_kind,
    output word_t      es_br_target,
    output logic       es_ex,
    output exc_code_t  es_exc_code
);

    inst_word_t ds_inst;
    logic       ds_fs_ex;
    exc_code_t  ds_fs_exc_code;
    logic       load_stall;
    word_t      rdata1;
    word_t      rdata2;
    word_t      rs_value;
    word_t      rt_value;
    logic       rs_read;
    logic       rt_read;
    imm_kind_t  imm_kind;
    logic       src1_is_sa;
    logic       src1_is_pc;
    logic       src2_is_8;

    id_stage_reg u_stage_reg (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_inst        (fs_inst),
        .fs_pc          (fs_pc),
        .fs_ex          (fs_ex),
        .fs_exc_code    (fs_exc_code),
        .es_allowin     (es_allowin),
        .load_stall     (load_stall),
        .ds_valid       (),
        .ds_inst        (ds_inst),
        .ds_pc          (es_pc),
        .ds_fs_ex       (ds_fs_ex),
        .ds_fs_exc_code (ds_fs_exc_code),
        .ds_allowin     (ds_allowin),
        .ds_to_es_valid (ds_to_es_valid)
    );

    id_decoder u_decoder (
        .ds_inst        (ds_inst),
        .ds_fs_ex       (ds_fs_ex),
        .ds_fs_exc_code (ds_fs_exc_code),
        .rs_read        (rs_read),
        .rt_read        (rt_read),
        .alu_op         (es_alu_op),
        .imm_kind       (imm_kind),
        .src1_is_sa     (src1_is_sa),
        .src1_is_pc     (src1_is_pc),
        .src2_is_8      (src2_is_8),
        .dest           (es_dest),
        .gr_we          (es_gr_we),
        .mem_we         (es_mem_we),
        .load_op        (es_load_op_out),
        .br_kind        (es_br_kind),
        .ds_ex          (es_ex),
        .exc_code       (es_exc_code)
    );

    id_regfile u_regfile (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (ds_inst.i.rs),
        .raddr2 (ds_inst.i.rt),
        .we     (wb_we),
        .waddr  (wb_waddr),
        .wdata  (wb_wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    id_bypass u_bypass (
        .ds_inst    (ds_inst),
        .rs_read    (rs_read),
        .rt_read    (rt_read),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .exe_dest   (exe_dest),
        .mem_dest   (mem_dest),
        .wb_dest    (wb_dest),
        .exe_result (exe_result),
        .mem_result (mem_result),
        .wb_result  (wb_result),
        .es_load_op (es_load_op),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .load_stall (load_stall)
    );

    id_operand_sel u_operand_sel (
        .ds_inst    (ds_inst),
        .ds_pc      (es_pc),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .imm_kind   (imm_kind),
        .src1_is_sa (src1_is_sa),
        .src1_is_pc (src1_is_pc),
        .src2_is_8  (src2_is_8),
        .br_kind    (es_br_kind),
        .src1       (es_src1),
        .src2       (es_src2),
        .store_data (es_store_data),
        .br_target  (es_br_target)
    );

endmodule

//--- tb_id_stage.sv
module tb_id_stage
    import mips_isa_pkg::*;
    import id_ctrl_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_INST   = 300;
    localparam int NUM_KINDS  = 28;
    localparam int K_SYS      = 12;
    localparam int K_BRK      = 13;
    localparam int K_LW       = 20;
    localparam int K_SW       = 21;
    localparam int K_ILL      = 27;
    // 31 init writes plus about 4 cycles per instruction under random back-pressure, doubled
    localparam int MAX_CYCLES = 3000;

    logic       clk = 1'b0;
    logic       reset;
    logic       flush;
    logic       fs_to_ds_valid;
    logic       fs_ex;
    inst_word_t fs_inst;
    word_t      fs_pc;
    exc_code_t  fs_exc_code;
    logic       es_allowin;
    logic       es_load_op;
    reg_addr_t  exe_dest;
    reg_addr_t  mem_dest;
    reg_addr_t  wb_dest;
    word_t      exe_result;
    word_t      mem_result;
    word_t      wb_result;
    logic       wb_we;
    reg_addr_t  wb_waddr;
    word_t      wb_wdata;
    logic       ds_allowin;
    logic       ds_to_es_valid;
    word_t      es_pc;
    alu_op_t    es_alu_op;
    word_t      es_src1;
    word_t      es_src2;
    word_t      es_store_data;
    reg_addr_t  es_dest;
    logic       es_gr_we;
    logic       es_mem_we;
    logic       es_load_op_out;
    br_kind_t   es_br_kind;
    word_t      es_br_target;
    logic       es_ex;
    exc_code_t  es_exc_code;

    integer seed;
    int     errors = 0;
    int     sent = 0;
    int     cycles = 0;
    int     fs_kind = K_ILL;

    // reference table, one row per instruction kind
    logic [5:0] ref_code [NUM_KINDS];
    alu_op_t    ref_alu  [NUM_KINDS];
    int         ref_dsel [NUM_KINDS];  // 0 none, 1 rd, 2 rt, 3 ra
    int         ref_s1   [NUM_KINDS];  // 0 rs, 1 shamt, 2 pc
    int         ref_s2   [NUM_KINDS];  // 0 rt, 1 zext imm, 2 sext imm, 3 eight
    br_kind_t   ref_br   [NUM_KINDS];
    logic       ref_rsu  [NUM_KINDS];
    logic       ref_rtu  [NUM_KINDS];

    word_t      shadow [32] = '{default: '0};
    int         rec_kind = K_ILL;
    inst_word_t rec_inst = '0;
    word_t      rec_pc = '0;
    logic       rec_fs_ex = 1'b0;
    exc_code_t  rec_fs_code = '0;
    logic       tb_valid;

    alu_op_t    exp_alu;
    reg_addr_t  exp_dest;
    word_t      exp_src1;
    word_t      exp_src2;
    word_t      exp_rt_v;
    word_t      exp_target;
    br_kind_t   exp_br;
    logic       exp_ex;
    exc_code_t  exp_code;
    logic       exp_stall;
    logic       exp_allowin;

    id_stage id_stage_i (.*);

    always #20 clk = ~clk;

    function automatic word_t source_value(reg_addr_t src, logic used);
        if (used && src != 0 && src == exe_dest) return exe_result;
        if (used && src != 0 && src == mem_dest) return mem_result;
        if (used && src != 0 && src == wb_dest) return wb_result;
        return shadow[src];
    endfunction

    always_comb begin
        word_t rs_v;
        word_t sext;
        word_t pc4;
        rs_v     = source_value(rec_inst.i.rs, ref_rsu[rec_kind]);
        exp_rt_v = source_value(rec_inst.i.rt, ref_rtu[rec_kind]);
        sext     = {{16{rec_inst.i.imm[15]}}, rec_inst.i.imm};
        pc4      = rec_pc + 4;
        exp_alu  = ref_alu[rec_kind];
        exp_br   = ref_br[rec_kind];
        case (ref_dsel[rec_kind])
            1:       exp_dest = rec_inst.r.rd;
            2:       exp_dest = rec_inst.i.rt;
            3:       exp_dest = 5'd31;
            default: exp_dest = 5'd0;
        endcase
        case (ref_s1[rec_kind])
            1:       exp_src1 = {27'b0, rec_inst.r.shamt};
            2:       exp_src1 = rec_pc;
            default: exp_src1 = rs_v;
        endcase
        case (ref_s2[rec_kind])
            1:       exp_src2 = {16'b0, rec_inst.i.imm};
            2:       exp_src2 = sext;
            3:       exp_src2 = 32'd8;
            default: exp_src2 = exp_rt_v;
        endcase
        case (exp_br)
            BR_BEQ, BR_BNE: exp_target = pc4 + (sext << 2);
            BR_J, BR_JAL:   exp_target = {pc4[31:28], rec_inst[25:0], 2'b00};
            default:        exp_target = rs_v;
        endcase
        exp_ex   = rec_fs_ex || rec_kind == K_ILL || rec_kind == K_SYS || rec_kind == K_BRK;
        exp_code = rec_fs_ex ? rec_fs_code :
                   (rec_kind == K_ILL) ? 5'd10 :
                   (rec_kind == K_SYS) ? 5'd8 :
                   (rec_kind == K_BRK) ? 5'd9 : 5'd0;
        exp_stall = es_load_op && exe_dest != 0 &&
                    ((ref_rsu[rec_kind] && rec_inst.i.rs == exe_dest) ||
                     (ref_rtu[rec_kind] && rec_inst.i.rt == exe_dest));
        exp_allowin = !tb_valid || (!exp_stall && es_allowin);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (fs_to_ds_valid && ds_allowin) begin
            rec_kind    <= fs_kind;
            rec_inst    <= fs_inst;
            rec_pc      <= fs_pc;
            rec_fs_ex   <= fs_ex;
            rec_fs_code <= fs_exc_code;
        end
        if (wb_we && wb_waddr != 0) begin
            shadow[wb_waddr] <= wb_wdata;
        end
        if (reset || flush) begin
            tb_valid <= 1'b0;
        end else if (exp_allowin) begin
            tb_valid <= fs_to_ds_valid;
        end
        if (cycles == MAX_CYCLES) begin
            $display("timeout: run stalled after %0d cycles, %0d errors", cycles, errors);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
        errors++;
        $display("ERR %s expected %h actual %h", name, exp, act);
    endtask

    task automatic problem(input string what);
        errors++;
        $display("%s at %0t", what, $time);
    endtask

    chk_alu: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid |-> es_alu_op == exp_alu)
        else mismatch("alu_op", $sampled(exp_alu), $sampled(es_alu_op));
    chk_pc: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid |-> es_pc == rec_pc)
        else mismatch("pc", $sampled(rec_pc), $sampled(es_pc));
    chk_dest: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid |-> es_dest == exp_dest && es_gr_we == (exp_dest != 0))
        else mismatch("dest", $sampled({exp_dest, exp_dest != 5'd0}),
                      $sampled({es_dest, es_gr_we}));
    chk_mem: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid |-> es_mem_we == (rec_kind == K_SW) && es_load_op_out == (rec_kind == K_LW))
        else mismatch("mem_we/load", $sampled({rec_kind == K_SW, rec_kind == K_LW}),
                      $sampled({es_mem_we, es_load_op_out}));
    chk_br: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid |-> es_br_kind == exp_br)
        else mismatch("br_kind", $sampled(exp_br), $sampled(es_br_kind));
    chk_src1: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid |-> es_src1 == exp_src1)
        else mismatch("src1", $sampled(exp_src1), $sampled(es_src1));
    chk_src2: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid |-> es_src2 == exp_src2)
        else mismatch("src2", $sampled(exp_src2), $sampled(es_src2));
    chk_store: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid && rec_kind == K_SW |-> es_store_data == exp_rt_v)
        else mismatch("store_data", $sampled(exp_rt_v), $sampled(es_store_data));
    chk_target: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid && exp_br != BR_NONE |-> es_br_target == exp_target)
        else mismatch("br_target", $sampled(exp_target), $sampled(es_br_target));
    chk_ex: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid |-> es_ex == exp_ex)
        else mismatch("ex", $sampled(exp_ex), $sampled(es_ex));
    chk_code: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid && exp_ex |-> es_exc_code == exp_code)
        else mismatch("exc_code", $sampled(exp_code), $sampled(es_exc_code));
    chk_allowin: assert property (@(posedge clk) disable iff (reset)
        ds_allowin == exp_allowin && ds_to_es_valid == (tb_valid && !exp_stall))
        else mismatch("handshake", $sampled({exp_allowin, tb_valid && !exp_stall}),
                      $sampled({ds_allowin, ds_to_es_valid}));
    chk_stall: assert property (@(posedge clk) disable iff (reset)
        tb_valid && exp_stall |-> !ds_to_es_valid && !ds_allowin)
        else problem("load-use hazard did not stall the stage");
    chk_flush: assert property (@(posedge clk) disable iff (reset)
        flush |=> !ds_to_es_valid)
        else problem("stage still offered an instruction after a flush");
    chk_hold: assert property (@(posedge clk) disable iff (reset)
        tb_valid && !es_allowin && !flush |=> $stable(es_pc) && $stable(es_alu_op) &&
        $stable(es_dest) && $stable(es_ex) && $stable(es_br_kind))
        else problem("outputs changed while EXE held back");
    chk_reset: assert property (@(posedge clk) $fell(reset) |-> ds_allowin)
        else problem("stage not ready to accept after reset");

    task automatic set_ref(input int k, input logic [5:0] code, input alu_op_t alu,
                           input int dsel, input int s1, input int s2, input br_kind_t br,
                           input logic rsu, input logic rtu);
        ref_code[k] = code;
        ref_alu[k]  = alu;
        ref_dsel[k] = dsel;
        ref_s1[k]   = s1;
        ref_s2[k]   = s2;
        ref_br[k]   = br;
        ref_rsu[k]  = rsu;
        ref_rtu[k]  = rtu;
    endtask

    initial begin
        set_ref(0, FN_ADDU, ALU_ADD, 1, 0, 0, BR_NONE, 1, 1);
        set_ref(1, FN_SUBU, ALU_SUB, 1, 0, 0, BR_NONE, 1, 1);
        set_ref(2, FN_AND, ALU_AND, 1, 0, 0, BR_NONE, 1, 1);
        set_ref(3, FN_OR, ALU_OR, 1, 0, 0, BR_NONE, 1, 1);
        set_ref(4, FN_XOR, ALU_XOR, 1, 0, 0, BR_NONE, 1, 1);
        set_ref(5, FN_NOR, ALU_NOR, 1, 0, 0, BR_NONE, 1, 1);
        set_ref(6, FN_SLT, ALU_SLT, 1, 0, 0, BR_NONE, 1, 1);
        set_ref(7, FN_SLTU, ALU_SLTU, 1, 0, 0, BR_NONE, 1, 1);
        set_ref(8, FN_SLL, ALU_SLL, 1, 1, 0, BR_NONE, 0, 1);
        set_ref(9, FN_SRL, ALU_SRL, 1, 1, 0, BR_NONE, 0, 1);
        set_ref(10, FN_SRA, ALU_SRA, 1, 1, 0, BR_NONE, 0, 1);
        set_ref(11, FN_JR, ALU_ADD, 0, 0, 0, BR_JR, 1, 0);
        set_ref(K_SYS, FN_SYSCALL, ALU_ADD, 0, 0, 0, BR_NONE, 0, 0);
        set_ref(K_BRK, FN_BREAK, ALU_ADD, 0, 0, 0, BR_NONE, 0, 0);
        set_ref(14, OP_ADDIU, ALU_ADD, 2, 0, 2, BR_NONE, 1, 0);
        set_ref(15, OP_SLTI, ALU_SLT, 2, 0, 2, BR_NONE, 1, 0);
        set_ref(16, OP_SLTIU, ALU_SLTU, 2, 0, 2, BR_NONE, 1, 0);
        set_ref(17, OP_ANDI, ALU_AND, 2, 0, 1, BR_NONE, 1, 0);
        set_ref(18, OP_ORI, ALU_OR, 2, 0, 1, BR_NONE, 1, 0);
        set_ref(19, OP_XORI, ALU_XOR, 2, 0, 1, BR_NONE, 1, 0);
        set_ref(K_LW, OP_LW, ALU_ADD, 2, 0, 2, BR_NONE, 1, 0);
        set_ref(K_SW, OP_SW, ALU_ADD, 0, 0, 2, BR_NONE, 1, 1);
        set_ref(22, OP_BEQ, ALU_ADD, 0, 0, 0, BR_BEQ, 1, 1);
        set_ref(23, OP_BNE, ALU_ADD, 0, 0, 0, BR_BNE, 1, 1);
        set_ref(24, OP_LUI, ALU_LUI, 2, 0, 1, BR_NONE, 0, 0);
        set_ref(25, OP_J, ALU_ADD, 0, 0, 0, BR_J, 0, 0);
        set_ref(26, OP_JAL, ALU_ADD, 3, 2, 3, BR_JAL, 0, 0);
        set_ref(K_ILL, 6'h3f, ALU_ADD, 0, 0, 0, BR_NONE, 0, 0);
    end

    // registers drawn from 0..7 so forwarding matches are frequent
    task automatic new_inst(input int k, output inst_word_t w);
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [31:0] rnd;
        rs  = $random(seed) & 7;
        rt  = $random(seed) & 7;
        rd  = $random(seed) & 7;
        rnd = $random(seed);
        if (k <= 7) w = {OP_SPECIAL, rs, rt, rd, 5'd0, ref_code[k]};
        else if (k <= 10) w = {OP_SPECIAL, 5'd0, rt, rd, rnd[4:0], ref_code[k]};
        else if (k == 11) w = {OP_SPECIAL, rs, 15'd0, ref_code[k]};
        else if (k <= K_BRK) w = {OP_SPECIAL, rnd[19:0], ref_code[k]};
        else if (k <= 23) w = {ref_code[k], rs, rt, rnd[15:0]};
        else if (k == 24) w = {ref_code[k], 5'd0, rt, rnd[15:0]};
        else if (k <= 26) w = {ref_code[k], rnd[25:0]};
        else if (rnd[31]) w = {6'h3f, rnd[25:0]};
        else w = {OP_SPECIAL, rnd[19:0], 6'h3f};  // unused function code
    endtask

    task automatic drive_env();
        es_allowin <= ({$random(seed)} % 4 != 0);
        flush      <= ({$random(seed)} % 16 == 0);
        es_load_op <= ({$random(seed)} % 4 == 0);
        exe_dest   <= $random(seed) & 7;
        mem_dest   <= $random(seed) & 7;
        wb_dest    <= $random(seed) & 7;
        exe_result <= $random(seed);
        mem_result <= $random(seed);
        wb_result  <= $random(seed);
        wb_we      <= $random(seed) & 1;
        wb_waddr   <= $random(seed) & 7;
        wb_wdata   <= $random(seed);
    endtask

    initial begin
        inst_word_t w;
        int         k;
        word_t      pc;
        seed = 32'hd031;
        pc   = 32'hbfc0_0000;
        reset <= 1'b1;
        flush <= 1'b0;
        fs_to_ds_valid <= 1'b0;
        fs_ex <= 1'b0;
        fs_inst <= '0;
        fs_pc <= '0;
        fs_exc_code <= '0;
        es_allowin <= 1'b0;
        es_load_op <= 1'b0;
        exe_dest <= '0;
        mem_dest <= '0;
        wb_dest <= '0;
        exe_result <= '0;
        mem_result <= '0;
        wb_result <= '0;
        wb_we <= 1'b0;
        wb_waddr <= '0;
        wb_wdata <= '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        for (int r = 1; r < 32; r++) begin  // fill the register file
            wb_we    <= 1'b1;
            wb_waddr <= r;
            wb_wdata <= $random(seed);
            @(posedge clk);
        end
        while (sent < NUM_INST) begin
            drive_env();
            if (!fs_to_ds_valid || ds_allowin) begin  // last offer consumed
                k = {$random(seed)} % NUM_KINDS;
                new_inst(k, w);
                fs_kind <= k;
                fs_inst <= w;
                fs_pc   <= pc;
                pc      = pc + 4;
                fs_ex   <= ({$random(seed)} % 16 == 0);
                fs_exc_code <= $random(seed) & 31;
                fs_to_ds_valid <= ({$random(seed)} % 4 != 0);
                sent++;
            end
            @(posedge clk);
        end
        es_allowin <= 1'b1;
        es_load_op <= 1'b0;
        flush      <= 1'b0;
        while (fs_to_ds_valid && !ds_allowin) @(posedge clk);
        fs_to_ds_valid <= 1'b0;
        repeat (6) @(posedge clk);
        $display("run done: %0d instructions, %0d cycles, %0d errors", sent, cycles, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- files.f
mips_isa_pkg.sv
id_ctrl_pkg.sv
id_decoder.sv
id_stage_reg.sv
id_regfile.sv
id_bypass.sv
id_operand_sel.sv
id_stage.sv
tb_id_stage.sv

//--- Bender.yml
package:
  name: id_stage

sources:
  - mips_isa_pkg.sv
  - id_ctrl_pkg.sv
  - id_decoder.sv
  - id_stage_reg.sv
  - id_regfile.sv
  - id_bypass.sv
  - id_operand_sel.sv
  - id_stage.sv
  - target: test
    files:
      - tb_id_stage.sv
